// ==== rtl/clmul_pkg.sv ====
package clmul_pkg;

    localparam int OPERAND_WIDTH = 64;
    localparam int LIMB_WIDTH    = OPERAND_WIDTH / 2;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [LIMB_WIDTH-1:0]    limb_t;
    typedef logic [2*LIMB_WIDTH-1:0]  limb_prod_t;   // top bit is always zero.
    typedef logic [PRODUCT_WIDTH-1:0] product_t;     // top bit is always zero.

    typedef enum logic [1:0] {
        pair_lo,
        pair_hi,
        pair_mid
    } pair_e;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_mult,
        st_write
    } eval_state_e;

    typedef struct packed {
        pair_e tag;
        limb_t x;
        limb_t y;
    } limb_pair_t;

    typedef struct packed {
        logic       valid;
        pair_e      tag;
        limb_prod_t data;
    } product_wr_t;

    typedef struct packed {
        limb_prod_t lo;
        limb_prod_t mid;
        limb_prod_t hi;
    } partials_t;

endpackage

// ==== rtl/limb_clmul.sv ====
module limb_clmul #(
    parameter int WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  clmul_pkg::limb_t      x,
    input  clmul_pkg::limb_t      y,
    output clmul_pkg::limb_prod_t result,
    output logic                  done
);
    localparam int CNT_W = $clog2(WIDTH);

    logic [2*WIDTH-1:0] x_sh;
    logic [WIDTH-1:0]   y_sh;
    logic [2*WIDTH-1:0] acc;
    logic [2*WIDTH-1:0] acc_next;
    logic [CNT_W-1:0]   count;
    logic               running;

    // one multiplier bit per cycle with the lsb first.
    assign acc_next = y_sh[0] ? (acc ^ x_sh) : acc;

    // y_sh is empty once all bits are used, so acc_next then equals acc.
    assign result = acc_next;
    assign done   = running && (count == '0);   // result already includes the last shift.

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            count   <= '0;
        end else if (load) begin
            running <= 1'b1;
            count   <= CNT_W'(WIDTH - 1);
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            acc  <= '0;
            x_sh <= {{WIDTH{1'b0}}, x};
            y_sh <= y;
        end else if (running) begin
            acc  <= acc_next;
            x_sh <= x_sh << 1;
            y_sh <= y_sh >> 1;
        end
    end

endmodule

// ==== rtl/operand_eval.sv ====
module operand_eval (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  clmul_pkg::operand_t    a,
    input  clmul_pkg::operand_t    b,
    output logic                   busy,
    output logic                   clear,
    output clmul_pkg::product_wr_t wr
);
    clmul_pkg::eval_state_e state;
    clmul_pkg::pair_e       pair;
    clmul_pkg::operand_t    op_a;
    clmul_pkg::operand_t    op_b;
    clmul_pkg::limb_t       a_lo;
    clmul_pkg::limb_t       a_hi;
    clmul_pkg::limb_t       b_lo;
    clmul_pkg::limb_t       b_hi;
    clmul_pkg::limb_pair_t  job;
    clmul_pkg::limb_prod_t  mul_result;
    logic                   mul_done;
    logic                   accept;

    assign accept = (state == clmul_pkg::st_idle) && start;   // start is dropped while busy.
    assign busy   = (state != clmul_pkg::st_idle);

    assign {a_hi, a_lo} = op_a;
    assign {b_hi, b_lo} = op_b;

    // the two-way split evaluates at 0, infinity and 1.
    always_comb begin
        job.tag = pair;
        case (pair)
            clmul_pkg::pair_lo: begin
                job.x = a_lo;
                job.y = b_lo;
            end
            clmul_pkg::pair_hi: begin
                job.x = a_hi;
                job.y = b_hi;
            end
            default: begin
                job.x = a_lo ^ a_hi;
                job.y = b_lo ^ b_hi;
            end
        endcase
    end

    limb_clmul #(
        .WIDTH(clmul_pkg::LIMB_WIDTH)
    ) u_limb_clmul (
        .clk    (clk),
        .reset  (reset),
        .load   (state == clmul_pkg::st_load),
        .x      (job.x),
        .y      (job.y),
        .result (mul_result),
        .done   (mul_done)
    );

    // multiplier holds its result, so the write is taken straight from it.
    always_comb begin
        wr.valid = (state == clmul_pkg::st_write);
        wr.tag   = job.tag;
        wr.data  = mul_result;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= clmul_pkg::st_idle;
            pair  <= clmul_pkg::pair_lo;
            clear <= 1'b0;
        end else begin
            clear <= accept;
            case (state)
                clmul_pkg::st_idle: begin
                    if (accept) begin
                        pair  <= clmul_pkg::pair_lo;
                        state <= clmul_pkg::st_load;
                    end
                end
                clmul_pkg::st_load: begin
                    state <= clmul_pkg::st_mult;
                end
                clmul_pkg::st_mult: begin
                    if (mul_done) begin
                        state <= clmul_pkg::st_write;
                    end
                end
                clmul_pkg::st_write: begin
                    if (pair == clmul_pkg::pair_mid) begin
                        state <= clmul_pkg::st_idle;
                    end else begin
                        pair  <= (pair == clmul_pkg::pair_lo) ? clmul_pkg::pair_hi
                                                              : clmul_pkg::pair_mid;
                        state <= clmul_pkg::st_load;
                    end
                end
                default: state <= clmul_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_a <= a;
            op_b <= b;
        end
    end

endmodule

// ==== rtl/product_store.sv ====
module product_store (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clear,
    input  clmul_pkg::product_wr_t wr,
    output clmul_pkg::partials_t   partials,
    output logic                   complete
);
    logic [2:0] valid;        // bit order follows pair_e.
    logic [2:0] sel;
    logic [2:0] valid_next;

    assign sel        = wr.valid ? (3'b001 << wr.tag) : 3'b000;
    assign valid_next = valid | sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid    <= 3'b000;
            complete <= 1'b0;
        end else if (clear) begin
            valid    <= 3'b000;
            complete <= 1'b0;
        end else begin
            valid    <= valid_next;
            complete <= (valid != 3'b111) && (valid_next == 3'b111);   // only on the last arrival.
        end
    end

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            case (wr.tag)
                clmul_pkg::pair_lo:  partials.lo  <= wr.data;
                clmul_pkg::pair_hi:  partials.hi  <= wr.data;
                clmul_pkg::pair_mid: partials.mid <= wr.data;
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/interp_recombine.sv ====
module interp_recombine (
    input  logic                 clk,
    input  logic                 reset,
    input  clmul_pkg::partials_t partials,
    input  logic                 complete,
    output clmul_pkg::product_t  product,
    output logic                 done
);
    clmul_pkg::limb_prod_t middle;
    clmul_pkg::product_t   lo_ext;
    clmul_pkg::product_t   mid_ext;
    clmul_pkg::product_t   hi_ext;
    clmul_pkg::product_t   product_next;

    // in GF(2) the karatsuba subtraction is a plain xor.
    assign middle = partials.mid ^ partials.lo ^ partials.hi;

    assign lo_ext  = clmul_pkg::product_t'(partials.lo);
    assign mid_ext = clmul_pkg::product_t'(middle);
    assign hi_ext  = clmul_pkg::product_t'(partials.hi);

    assign product_next = lo_ext
                        ^ (mid_ext << clmul_pkg::LIMB_WIDTH)
                        ^ (hi_ext << clmul_pkg::OPERAND_WIDTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            product <= '0;
            done    <= 1'b0;
        end else begin
            done <= complete;
            if (complete) begin
                product <= product_next;   // held until the next job completes.
            end
        end
    end

endmodule

// ==== rtl/karatsuba_clmul_top.sv ====
module karatsuba_clmul_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  clmul_pkg::operand_t a,
    input  clmul_pkg::operand_t b,
    output logic                busy,
    output logic                done,
    output clmul_pkg::product_t product
);
    logic                   clear;
    logic                   complete;
    clmul_pkg::product_wr_t wr;
    clmul_pkg::partials_t   partials;

    operand_eval u_operand_eval (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .a     (a),
        .b     (b),
        .busy  (busy),
        .clear (clear),
        .wr    (wr)
    );

    product_store u_product_store (
        .clk      (clk),
        .reset    (reset),
        .clear    (clear),
        .wr       (wr),
        .partials (partials),
        .complete (complete)
    );

    interp_recombine u_interp_recombine (
        .clk      (clk),
        .reset    (reset),
        .partials (partials),
        .complete (complete),
        .product  (product),
        .done     (done)
    );

endmodule

// ==== dv/karatsuba_clmul_assert.sv ====
module karatsuba_clmul_assert (
    input logic clk,
    input logic reset,
    input logic start,
    input logic busy,
    input logic done
);
    timeunit 1ns;
    timeprecision 1ps;

    a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_done_idle: assert property (@(posedge clk) disable iff (reset) done |-> !busy)
        else $error("done seen while busy was high");

    // an accepted start raises busy on the next edge.
    a_start_busy: assert property (@(posedge clk) disable iff (reset) (start && !busy) |=> busy)
        else $error("busy did not follow an accepted start");

endmodule

bind karatsuba_clmul_top karatsuba_clmul_assert u_karatsuba_clmul_assert (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .busy  (busy),
    .done  (done)
);

// ==== dv/tb_karatsuba_clmul.sv ====
module tb_karatsuba_clmul;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT     = 500;
    localparam int RANDOM_JOBS = 60;

    logic                clk = 1'b0;
    logic                reset;
    logic                start;
    clmul_pkg::operand_t a;
    clmul_pkg::operand_t b;
    logic                busy;
    logic                done;
    clmul_pkg::product_t product;

    clmul_pkg::product_t exp_q[$];   // expected products of accepted starts, oldest first.
    int                  jobs_sent    = 0;
    int                  jobs_checked = 0;
    logic [31:0]         lfsr_state   = 32'd2;

    karatsuba_clmul_top UUT (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .a       (a),
        .b       (b),
        .busy    (busy),
        .done    (done),
        .product (product)
    );

    always #2 clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    // schoolbook carry-less product built one output bit at a time.
    function automatic clmul_pkg::product_t clmul_ref(input clmul_pkg::operand_t x,
                                                      input clmul_pkg::operand_t y);
        clmul_pkg::product_t r;
        r = '0;
        for (int k = 0; k < clmul_pkg::PRODUCT_WIDTH; k++) begin
            for (int i = 0; i < clmul_pkg::OPERAND_WIDTH; i++) begin
                if ((k - i >= 0) && (k - i < clmul_pkg::OPERAND_WIDTH)) begin
                    r[k] = r[k] ^ (x[i] & y[k-i]);
                end
            end
        end
        return r;
    endfunction

    task automatic random_operand(output clmul_pkg::operand_t op);
        for (int i = 0; i < clmul_pkg::OPERAND_WIDTH; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            op[i]      = lfsr_state[0];
        end
    endtask

    task automatic stop_on_failure(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    task automatic check_product(input clmul_pkg::product_t actual,
                                 input clmul_pkg::product_t expected,
                                 input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s, got %h, expected %h", $time, what, actual, expected);
            stop_on_failure("product mismatch");
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s, got %b, expected %b", $time, what, actual, expected);
            stop_on_failure("flag mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout after %0d cycles while waiting for %s", TIMEOUT, what);
        stop_on_failure("wait timed out");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) timeout_fail("busy to go low");
    endtask

    task automatic wait_checked();
        int n;
        n = 0;
        while (jobs_checked != jobs_sent && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (jobs_checked != jobs_sent) timeout_fail("the result of the last job");
    endtask

    task automatic issue_start(input clmul_pkg::operand_t op_a, input clmul_pkg::operand_t op_b);
        wait_idle();
        a     = op_a;
        b     = op_b;
        start = 1'b1;
        exp_q.push_back(clmul_ref(op_a, op_b));
        jobs_sent++;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_job(input clmul_pkg::operand_t op_a, input clmul_pkg::operand_t op_b);
        issue_start(op_a, op_b);
        wait_checked();
    endtask

    // a second start lands mid job and has to be dropped.
    task automatic start_while_busy(input clmul_pkg::operand_t a1, input clmul_pkg::operand_t b1,
                                    input clmul_pkg::operand_t a2, input clmul_pkg::operand_t b2);
        issue_start(a1, b1);
        repeat (10) @(negedge clk);
        check_flag(busy, 1'b1, "busy before the extra start");
        a     = a2;
        b     = b2;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_checked();
    endtask

    initial begin : stimulus
        clmul_pkg::operand_t ra;
        clmul_pkg::operand_t rb;
        reset = 1'b1;
        start = 1'b0;
        a     = '0;
        b     = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_product(product, '0, "product after reset");

        run_job(64'h0, 64'hDEAD_BEEF_CAFE_F00D);
        run_job(64'h0123_4567_89AB_CDEF, 64'h0);
        run_job(64'h1, 64'h0123_4567_89AB_CDEF);
        run_job(64'hFEDC_BA98_7654_3210, 64'h1);
        run_job({64{1'b1}}, {64{1'b1}});
        run_job(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
        run_job(64'h8000_0000_0000_0000, 64'h0000_0001_0000_0000);
        run_job(64'h0000_0001_0000_0000, 64'h0000_0000_8000_0000);
        run_job(64'hFFFF_FFFF_0000_0000, 64'h0000_0000_FFFF_FFFF);
        run_job(64'h8000_0001_8000_0001, 64'hFFFF_FFFF_0000_0001);

        for (int j = 0; j < RANDOM_JOBS; j++) begin
            random_operand(ra);
            random_operand(rb);
            run_job(ra, rb);
        end

        start_while_busy(64'h1357_9BDF_0246_8ACE, 64'hF0F0_0F0F_A5A5_5A5A,
                         64'hFFFF_FFFF_FFFF_FFFF, 64'h1234_5678_9ABC_DEF0);
        repeat (20) @(negedge clk);   // product must hold over an idle gap.
        run_job(64'hA5A5_A5A5_A5A5_A5A5, 64'h5A5A_5A5A_5A5A_5A5A);
        repeat (20) @(negedge clk);

        $display("=== PASS ===");
        $finish;
    end

    initial begin : compare
        clmul_pkg::product_t expected;
        clmul_pkg::product_t held;
        logic                seen;
        int                  n;
        held = '0;
        forever begin
            n = 0;
            while (exp_q.size() == 0 && n < TIMEOUT) begin
                @(negedge clk);
                if (!reset) begin
                    check_flag(done, 1'b0, "done without an accepted start");
                    check_product(product, held, "product held while idle");
                end
                n++;
            end
            if (exp_q.size() == 0) timeout_fail("an accepted start");
            expected = exp_q.pop_front();
            seen     = 1'b0;
            n        = 0;
            while (!seen && n < TIMEOUT) begin
                @(negedge clk);
                if (done) begin
                    seen = 1'b1;
                end else begin
                    check_product(product, held, "product held while busy");
                end
                n++;
            end
            if (!seen) timeout_fail("done");
            check_product(product, expected, "product");
            held = expected;
            jobs_checked++;
            @(negedge clk);
            check_flag(done, 1'b0, "done one cycle after it rose");
        end
    end

endmodule

// ==== build.f ====
rtl/clmul_pkg.sv
rtl/limb_clmul.sv
rtl/operand_eval.sv
rtl/product_store.sv
rtl/interp_recombine.sv
rtl/karatsuba_clmul_top.sv
dv/karatsuba_clmul_assert.sv
dv/tb_karatsuba_clmul.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the carry-less multiplier testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_karatsuba_clmul \
    -Mdir obj_dir \
    -f build.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_karatsuba_clmul
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished with status 0"
exit 0
